// File: verilog/game_pkg.sv
// shared game constants and the step pattern of the ladder
// struct types for buttons, draw commands and segment patterns
package game_pkg;

    // ladder geometry
    localparam int NUM_STEPS = 33;                  // steps per player
    localparam int STEP_W    = 6;                   // wide enough for 0..32

    // bit i set means step i wants the right button
    // read from bit 0 upwards: R L L R L L L R L R R L R L L R R L R R R L R L R L L L R L R R L
    localparam logic [NUM_STEPS-1:0] STEP_PATTERN =
        33'b0_1101_0001_0101_1101_1001_0110_1000_1001;

    // screen placement of the boxes
    localparam int Y_START = 100;                   // y of step 0
    localparam int Y_PITCH = 3;                     // rows climbed per step

    // field widths
    localparam int X_W      = 8;                    // 160 columns
    localparam int Y_W      = 7;                    // 120 rows
    localparam int COLOUR_W = 3;                    // rgb, one bit each
    localparam int MISS_W   = 8;                    // two hex digits

    // box draw request, valid for exactly one cycle
    typedef struct packed {
        logic                valid;                 // take it this cycle
        logic [X_W-1:0]      x;                     // lane column
        logic [Y_W-1:0]      y;                     // row of the step
        logic [COLOUR_W-1:0] colour;                // player colour
    } draw_cmd_t;

    // press levels of one player, active high
    typedef struct packed {
        logic left;
        logic right;
    } buttons_t;

    // seven-segment digit, active low, segment a in bit 0
    typedef logic [6:0] seg7_t;

endpackage

// File: verilog/game_control.sv
// game phase FSM with idle, playing and done states
// latches which player reached the top first
module game_control (
    input  logic       clk,
    input  logic       resetn,                      // sync, active high
    input  logic       start,                       // level from the start switch
    input  logic [1:0] finish,                      // bit 0 player one, bit 1 player two
    output logic       running,
    output logic       done,
    output logic [1:0] winner
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAY,
        ST_DONE
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: if (start) state_next = ST_PLAY;        // game begins
            ST_PLAY: if (|finish) state_next = ST_DONE;      // someone reached the top
            ST_DONE: if (!start) state_next = ST_IDLE;       // wait for the switch to drop
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // both bits are taken together, so a tie marks both players
    always_ff @(posedge clk) begin
        if (resetn) begin
            winner <= '0;
        end else if (state == ST_PLAY && |finish) begin
            winner <= finish;                       // same edge as done rises
        end
    end

    assign running = (state == ST_PLAY);
    assign done    = (state == ST_DONE);

    // a finish in play ends the game on the next edge and names the finisher
    a_finish_ends_play: assert property (@(posedge clk) disable iff (resetn)
        running && (|finish) |=> done && winner == $past(finish));

    // done is only reachable through a finish from one of the tracks
    a_done_has_winner: assert property (@(posedge clk) disable iff (resetn)
        done |-> winner != 2'b00);

endmodule

// File: verilog/player_track.sv
// one player's lane: button edge detection, ladder position,
// miss counter and box draw pulses
module player_track #(
    parameter logic [game_pkg::X_W-1:0]      LANE_LEFT_X  = 8'd38,
    parameter logic [game_pkg::X_W-1:0]      LANE_RIGHT_X = 8'd43,
    parameter logic [game_pkg::COLOUR_W-1:0] BOX_COLOUR   = 3'b100
) (
    input  logic                         clk,
    input  logic                         resetn,    // sync, active high
    input  logic                         running,   // game in progress
    input  game_pkg::buttons_t           buttons,   // raw press levels
    output game_pkg::draw_cmd_t          draw,
    output logic [game_pkg::MISS_W-1:0]  miss,
    output logic                         finish
);
    import game_pkg::*;

    buttons_t            buttons_q;                 // levels seen last cycle
    logic                press_left;
    logic                press_right;
    logic                any_press;
    logic                single_press;
    logic                active;
    logic                expect_right;
    logic                hit;
    logic                wrong;
    logic [STEP_W-1:0]   step;                      // step the player stands on
    logic                last_step;
    logic [Y_W-1:0]      box_y;
    logic                draw_valid;
    logic [X_W-1:0]      draw_x;
    logic [Y_W-1:0]      draw_y;

    // edge register keeps tracking even when the game is not running,
    // so a button held through start does not count as a press
    always_ff @(posedge clk) begin
        if (resetn) begin
            buttons_q <= '0;
        end else begin
            buttons_q <= buttons;
        end
    end

    assign press_left   = buttons.left & ~buttons_q.left;       // rising edge only
    assign press_right  = buttons.right & ~buttons_q.right;
    assign any_press    = press_left | press_right;
    assign single_press = press_left ^ press_right;             // both at once is a miss

    assign active       = running & ~finish;                    // finished lane is frozen
    assign expect_right = STEP_PATTERN[step];
    assign last_step    = (step == STEP_W'(NUM_STEPS - 1));

    // right pressed on a right step, or left pressed on a left step
    assign hit   = active & single_press & (press_right == expect_right);
    assign wrong = active & any_press & ~hit;

    // boxes climb the screen as the step index grows
    assign box_y = Y_W'(Y_START - Y_PITCH * int'(step));

    always_ff @(posedge clk) begin
        if (resetn) begin
            step       <= '0;
            miss       <= '0;
            finish     <= 1'b0;
            draw_valid <= 1'b0;
        end else begin
            draw_valid <= hit;                      // one cycle pulse per good press
            if (wrong) begin
                miss <= miss + 1'b1;                // wraps at 8 bits
            end
            if (hit) begin
                if (last_step) begin
                    finish <= 1'b1;                 // top reached, step stays at 32
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // coordinates of the box for the step being completed
    always_ff @(posedge clk) begin
        if (hit) begin
            draw_x <= press_right ? LANE_RIGHT_X : LANE_LEFT_X;
            draw_y <= box_y;
        end
    end

    assign draw = '{valid: draw_valid, x: draw_x, y: draw_y, colour: BOX_COLOUR};

    a_step_range: assert property (@(posedge clk) disable iff (resetn)
        step <= STEP_W'(NUM_STEPS - 1));

    // a pulse may trail the fall of running by one cycle when the
    // other lane finishes, but the press itself was taken in play
    a_draw_in_play: assert property (@(posedge clk) disable iff (resetn)
        draw_valid |-> $past(running));

endmodule

// File: verilog/score_display.sv
// two seven-segment digits for an 8-bit miss count
// one shared hex table drives both nibbles
module score_display (
    input  logic                        clk,        // for the check below only
    input  logic                        resetn,
    input  logic [game_pkg::MISS_W-1:0] count,
    output game_pkg::seg7_t             seg_lo,
    output game_pkg::seg7_t             seg_hi
);
    import game_pkg::*;

    // active low, bit 0 is segment a, bit 6 is segment g
    function automatic seg7_t hex_to_seg(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b100_0000;
            4'h1: return 7'b111_1001;
            4'h2: return 7'b010_0100;
            4'h3: return 7'b011_0000;
            4'h4: return 7'b001_1001;
            4'h5: return 7'b001_0010;
            4'h6: return 7'b000_0010;
            4'h7: return 7'b111_1000;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b001_0000;
            4'ha: return 7'b000_1000;
            4'hb: return 7'b000_0011;               // lower case b
            4'hc: return 7'b100_0110;
            4'hd: return 7'b010_0001;               // lower case d
            4'he: return 7'b000_0110;
            default: return 7'b000_1110;            // F
        endcase
    endfunction

    assign seg_lo = hex_to_seg(count[3:0]);
    assign seg_hi = hex_to_seg(count[7:4]);

    // the counter upstream is cleared by reset and must stay defined
    a_count_known: assert property (@(posedge clk) disable iff (resetn)
        !$isunknown(count));

endmodule

// File: verilog/step_game_top.sv
// stepping race top level
// game controller, two player lanes and four score digits
module step_game_top #(
    parameter logic [game_pkg::X_W-1:0]      P1_LEFT_X  = 8'd38,
    parameter logic [game_pkg::X_W-1:0]      P1_RIGHT_X = 8'd43,
    parameter logic [game_pkg::COLOUR_W-1:0] P1_COLOUR  = 3'b100,    // red
    parameter logic [game_pkg::X_W-1:0]      P2_LEFT_X  = 8'd118,
    parameter logic [game_pkg::X_W-1:0]      P2_RIGHT_X = 8'd123,
    parameter logic [game_pkg::COLOUR_W-1:0] P2_COLOUR  = 3'b001     // blue
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         start,
    input  game_pkg::buttons_t           buttons_p1,
    input  game_pkg::buttons_t           buttons_p2,
    output logic                         running,
    output logic                         done,
    output logic [1:0]                   winner,    // bit 0 player one
    output game_pkg::draw_cmd_t          draw_p1,
    output game_pkg::draw_cmd_t          draw_p2,
    output logic                         finish_p1,
    output logic                         finish_p2,
    output logic [game_pkg::MISS_W-1:0]  miss_p1,
    output logic [game_pkg::MISS_W-1:0]  miss_p2,
    output game_pkg::seg7_t              hex_p1_lo,
    output game_pkg::seg7_t              hex_p1_hi,
    output game_pkg::seg7_t              hex_p2_lo,
    output game_pkg::seg7_t              hex_p2_hi
);

    game_control control (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .finish  ({finish_p2, finish_p1}),          // matches winner bit order
        .running (running),
        .done    (done),
        .winner  (winner)
    );

    player_track #(
        .LANE_LEFT_X  (P1_LEFT_X),
        .LANE_RIGHT_X (P1_RIGHT_X),
        .BOX_COLOUR   (P1_COLOUR)
    ) player_one (
        .clk     (clk),
        .resetn  (resetn),
        .running (running),
        .buttons (buttons_p1),
        .draw    (draw_p1),
        .miss    (miss_p1),
        .finish  (finish_p1)
    );

    player_track #(
        .LANE_LEFT_X  (P2_LEFT_X),
        .LANE_RIGHT_X (P2_RIGHT_X),
        .BOX_COLOUR   (P2_COLOUR)
    ) player_two (
        .clk     (clk),
        .resetn  (resetn),
        .running (running),
        .buttons (buttons_p2),
        .draw    (draw_p2),
        .miss    (miss_p2),
        .finish  (finish_p2)
    );

    score_display score_p1 (
        .clk    (clk),
        .resetn (resetn),
        .count  (miss_p1),
        .seg_lo (hex_p1_lo),
        .seg_hi (hex_p1_hi)
    );

    score_display score_p2 (
        .clk    (clk),
        .resetn (resetn),
        .count  (miss_p2),
        .seg_lo (hex_p2_lo),
        .seg_hi (hex_p2_hi)
    );

endmodule

// File: bench/step_game_tb.sv
// testbench for the stepping race top level
// stimulus table applied in a loop, cycle reference model of both lanes
// per-cycle output checks, error counting and a cycle timeout
module step_game_tb;
    import game_pkg::*;

    localparam int NAME_W   = 8 * 16;               // up to 16 characters per test name
    localparam int NUM_ROWS = 13;

    localparam buttons_t B_NONE  = 2'b00;
    localparam buttons_t B_LEFT  = 2'b10;           // left is the upper struct bit
    localparam buttons_t B_RIGHT = 2'b01;
    localparam buttons_t B_BOTH  = 2'b11;

    // lane columns and colours given to the top level
    localparam int P1_LEFT_X  = 38;
    localparam int P1_RIGHT_X = 43;
    localparam int P1_COLOUR  = 4;                  // red
    localparam int P2_LEFT_X  = 118;
    localparam int P2_RIGHT_X = 123;
    localparam int P2_COLOUR  = 1;                  // blue

    localparam int PH_IDLE = 0;
    localparam int PH_PLAY = 1;
    localparam int PH_DONE = 2;

    // active low digits, segment a in bit 0
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    typedef struct packed {
        logic [NAME_W-1:0] name;
        logic              start;
        logic              climb;                   // p1 presses whatever its step expects
        buttons_t          p1;
        buttons_t          p2;
        int                hold;                    // cycles the levels are held
        int                reps;                    // times the row is applied
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{"pre_start",     1'b0, 1'b0, B_RIGHT, B_LEFT,  2, 1},
        '{"start",         1'b1, 1'b0, B_NONE,  B_NONE,  2, 1},
        '{"p1_correct",    1'b1, 1'b0, B_RIGHT, B_NONE,  1, 1},
        '{"p2_correct",    1'b1, 1'b0, B_NONE,  B_RIGHT, 1, 1},
        '{"p1_wrong",      1'b1, 1'b0, B_RIGHT, B_NONE,  1, 1},
        '{"p1_wrong_held", 1'b1, 1'b0, B_RIGHT, B_NONE,  4, 1},
        '{"p1_double",     1'b1, 1'b0, B_BOTH,  B_NONE,  1, 1},
        '{"p2_double",     1'b1, 1'b0, B_LEFT,  B_BOTH,  1, 1},
        '{"mixed",         1'b1, 1'b0, B_RIGHT, B_LEFT,  1, 1},
        '{"p1_wrong_many", 1'b1, 1'b0, B_RIGHT, B_NONE,  1, 14},
        '{"p1_climb",      1'b1, 1'b1, B_NONE,  B_NONE,  1, 31},
        '{"after_finish",  1'b1, 1'b0, B_RIGHT, B_RIGHT, 2, 1},
        '{"stop",          1'b0, 1'b0, B_NONE,  B_NONE,  2, 1}
    };

    logic      clk;
    logic      resetn;
    logic      start;
    buttons_t  buttons_p1;
    buttons_t  buttons_p2;
    logic      running;
    logic      done;
    logic [1:0] winner;
    draw_cmd_t draw_p1;
    draw_cmd_t draw_p2;
    logic      finish_p1;
    logic      finish_p2;
    logic [MISS_W-1:0] miss_p1;
    logic [MISS_W-1:0] miss_p2;
    seg7_t     hex_p1_lo;
    seg7_t     hex_p1_hi;
    seg7_t     hex_p2_lo;
    seg7_t     hex_p2_hi;

    // reference model, index 0 is player one
    int        m_phase;
    int        m_winner;
    int        m_step [2];
    int        m_miss [2];
    bit        m_finish [2];
    buttons_t  m_prev [2];                          // levels seen at the last edge
    bit        m_dv [2];
    int        m_dx [2];
    int        m_dy [2];

    int        checks;
    int        errors;
    int        cycle_count;
    int        cycle_limit;

    step_game_top step_game_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .buttons_p1 (buttons_p1),
        .buttons_p2 (buttons_p2),
        .running    (running),
        .done       (done),
        .winner     (winner),
        .draw_p1    (draw_p1),
        .draw_p2    (draw_p2),
        .finish_p1  (finish_p1),
        .finish_p2  (finish_p2),
        .miss_p1    (miss_p1),
        .miss_p2    (miss_p2),
        .hex_p1_lo  (hex_p1_lo),
        .hex_p1_hi  (hex_p1_hi),
        .hex_p2_lo  (hex_p2_lo),
        .hex_p2_hi  (hex_p2_hi)
    );

    always #20 clk = ~clk;                          // period 40

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no end of test after %0d clock cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic string row_name(input logic [NAME_W-1:0] raw);
        string s;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", raw[i*8 +: 8])};   // skip the zero padding
            end
        end
        return s;
    endfunction

    // one clock edge of the game rules, applied to the levels now on the inputs
    task automatic model_step();
        bit        old_running;
        bit [1:0]  old_finish;
        buttons_t  cur;
        buttons_t  press;
        bit        active;
        bit        hit;
        old_running = (m_phase == PH_PLAY);
        old_finish  = {m_finish[1], m_finish[0]};
        for (int p = 0; p < 2; p++) begin
            cur    = (p == 0) ? buttons_p1 : buttons_p2;
            press  = cur & ~m_prev[p];              // new presses only
            active = old_running && !m_finish[p];
            hit    = active && (press.left ^ press.right) &&
                     (press.right == STEP_PATTERN[STEP_W'(m_step[p])]);
            m_dv[p] = hit;
            if (hit) begin
                if (p == 0) begin
                    m_dx[p] = press.right ? P1_RIGHT_X : P1_LEFT_X;
                end else begin
                    m_dx[p] = press.right ? P2_RIGHT_X : P2_LEFT_X;
                end
                m_dy[p] = Y_START - Y_PITCH * m_step[p];
                if (m_step[p] == NUM_STEPS - 1) begin
                    m_finish[p] = 1'b1;             // top step, position stays
                end else begin
                    m_step[p] = m_step[p] + 1;
                end
            end else if (active && (press.left || press.right)) begin
                m_miss[p] = (m_miss[p] + 1) % 256;  // 8 bit counter wraps
            end
            m_prev[p] = cur;
        end
        case (m_phase)
            PH_IDLE: if (start) m_phase = PH_PLAY;
            PH_PLAY: begin
                if (old_finish != 2'b00) begin
                    m_phase  = PH_DONE;
                    m_winner = int'(old_finish);    // a tie would mark both
                end
            end
            default: if (!start) m_phase = PH_IDLE;
        endcase
    endtask

    task automatic check_value(input string tname, input string field,
                               input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("ERR %s %s expected %0h actual %0h", tname, field, expected, actual);
        end
    endtask

    task automatic check_player(input string tname, input int p, input draw_cmd_t draw,
                                input logic [MISS_W-1:0] miss, input logic finish,
                                input seg7_t lo, input seg7_t hi);
        string tag;
        tag = $sformatf("p%0d", p + 1);
        check_value(tname, {tag, " finish"}, int'(m_finish[p]), int'(finish));
        check_value(tname, {tag, " miss"}, m_miss[p], int'(miss));
        check_value(tname, {tag, " hex lo"}, int'(SEG_TABLE[4'(m_miss[p])]), int'(lo));
        check_value(tname, {tag, " hex hi"}, int'(SEG_TABLE[4'(m_miss[p] >> 4)]), int'(hi));
        check_value(tname, {tag, " draw valid"}, int'(m_dv[p]), int'(draw.valid));
        if (m_dv[p]) begin                          // coordinates only mean something with valid
            check_value(tname, {tag, " draw x"}, m_dx[p], int'(draw.x));
            check_value(tname, {tag, " draw y"}, m_dy[p], int'(draw.y));
            check_value(tname, {tag, " draw colour"}, (p == 0) ? P1_COLOUR : P2_COLOUR,
                        int'(draw.colour));
        end
    endtask

    task automatic check_outputs(input string tname);
        check_value(tname, "running", int'(m_phase == PH_PLAY), int'(running));
        check_value(tname, "done", int'(m_phase == PH_DONE), int'(done));
        check_value(tname, "winner", m_winner, int'(winner));
        check_player(tname, 0, draw_p1, miss_p1, finish_p1, hex_p1_lo, hex_p1_hi);
        check_player(tname, 1, draw_p2, miss_p2, finish_p2, hex_p2_lo, hex_p2_hi);
    endtask

    // sample just after the edge, where every output is registered or settled
    task automatic clock_and_check(input string tname);
        @(posedge clk);
        #2;
        model_step();
        check_outputs(tname);
    endtask

    task automatic apply_row(input int r);
        string tname;
        tname = row_name(ROWS[r].name);
        for (int k = 0; k < ROWS[r].reps; k++) begin
            start      = ROWS[r].start;
            buttons_p1 = ROWS[r].p1;
            if (ROWS[r].climb) begin
                buttons_p1 = STEP_PATTERN[STEP_W'(m_step[0])] ? B_RIGHT : B_LEFT;
            end
            buttons_p2 = ROWS[r].p2;
            repeat (ROWS[r].hold) clock_and_check(tname);
            buttons_p1 = B_NONE;                    // release for one cycle
            buttons_p2 = B_NONE;
            clock_and_check(tname);
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b1;
        start       = 1'b0;
        buttons_p1  = B_NONE;
        buttons_p2  = B_NONE;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        m_phase     = PH_IDLE;
        m_winner    = 0;
        for (int p = 0; p < 2; p++) begin
            m_step[p]   = 0;
            m_miss[p]   = 0;
            m_finish[p] = 1'b0;
            m_prev[p]   = B_NONE;
            m_dv[p]     = 1'b0;
            m_dx[p]     = 0;
            m_dy[p]     = 0;
        end
        cycle_limit = 3 + 50;                       // reset cycles plus margin
        for (int r = 0; r < NUM_ROWS; r++) begin
            cycle_limit = cycle_limit + (ROWS[r].hold + 1) * ROWS[r].reps;
        end

        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b0;
        check_outputs("reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/game_pkg.sv
verilog/game_control.sv
verilog/player_track.sv
verilog/score_display.sv
verilog/step_game_top.sv
bench/step_game_tb.sv

// File: Makefile
# Verilator build and run for the stepping race testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= step_game_tb
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_EXE   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv bench/*.sv)
PASS_TEXT := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# the simulation status itself is ignored, the log decides
run: compile
	-$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "run passed, see $(LOG)"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
